// File: centroid_link_cfg.svh
`ifndef CENTROID_LINK_CFG_SVH
`define CENTROID_LINK_CFG_SVH

// active video area
`define SCREEN_W 1280
`define SCREEN_H 720

// four centroids per board, one x lane and one y lane each
`define NUM_COMS 4
`define NUM_LANES 8

// 74.25 MHz / 40 / 16 gives roughly 115 kbaud
`define CLKS_PER_TICK 40
`define TICKS_PER_BIT 16

// 11 data bits per frame, wide enough for an x coordinate
`define COM_WORD_W 11

// local crosshairs: red, green, blue, white
`define COLOR_LOCAL0 24'hFF0000
`define COLOR_LOCAL1 24'h00FF00
`define COLOR_LOCAL2 24'h0000FF
`define COLOR_LOCAL3 24'hFFFFFF

// secondary crosshairs: yellow, purple, orange, black
`define COLOR_SEC0 24'hFFFF00
`define COLOR_SEC1 24'hFF00FF
`define COLOR_SEC2 24'hFF8000
`define COLOR_SEC3 24'h000000

`endif

// File: centroid_link_pkg.sv
`default_nettype none

`include "centroid_link_cfg.svh"

package centroid_link_pkg;

  // ====================
  // pixel coordinates
  // ====================

  // 11 bits reach 2047, enough for 1280 columns
  typedef logic [$clog2(`SCREEN_W)-1:0] hpos_t;
  // 10 bits reach 1023, enough for 720 rows
  typedef logic [$clog2(`SCREEN_H)-1:0] vpos_t;

  // raw payload of one lane frame
  typedef logic [`COM_WORD_W-1:0] com_word_t;

  // red in the top byte, then green, then blue
  typedef logic [23:0] rgb_t;

  // ====================
  // lane receiver
  // ====================

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire

// File: oversample_tick_gen.sv
`default_nettype none

`include "centroid_link_cfg.svh"

module oversample_tick_gen (
  input  logic clk_pixel,
  input  logic recent_reset,
  output logic tick_o
);

  localparam int CNT_W = $clog2(`CLKS_PER_TICK);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_TICK - 1);

  logic [CNT_W-1:0] cnt_q;

  // free-running divider, one tick per wrap
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      tick_o <= 1'b0;
      if (cnt_q == CNT_LAST) begin
        cnt_q  <= '0;
        tick_o <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // all lanes count ticks, so a double tick would skew every bit slot
  a_tick_single : assert property (
    @(posedge clk_pixel) disable iff (recent_reset) tick_o |=> !tick_o
  );

endmodule

`default_nettype wire

// File: uart_lane_rx.sv
`default_nettype none

`include "centroid_link_cfg.svh"

module uart_lane_rx
  import centroid_link_pkg::*;
(
  input  logic      clk_pixel,
  input  logic      recent_reset,
  input  logic      rx_i,
  input  logic      tick_i,
  output com_word_t word_o,
  output logic      word_strobe_o
);

  localparam int TCNT_W = $clog2(`TICKS_PER_BIT);
  localparam int BCNT_W = $clog2(`COM_WORD_W);

  // half a bit lands in the middle of the start bit
  localparam logic [TCNT_W-1:0] TICK_MID  = TCNT_W'(`TICKS_PER_BIT / 2 - 1);
  localparam logic [TCNT_W-1:0] TICK_LAST = TCNT_W'(`TICKS_PER_BIT - 1);
  localparam logic [BCNT_W-1:0] BIT_LAST  = BCNT_W'(`COM_WORD_W - 1);

  // ====================
  // input synchronizer
  // ====================

  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic fall_edge;

  rx_state_e         state_q;
  logic [TCNT_W-1:0] tick_cnt_q;
  logic [BCNT_W-1:0] bit_cnt_q;
  com_word_t         shift_q;

  logic slot_end;
  logic sample_data;
  logic stop_good;

  // line idles high, a frame opens with a high to low step
  assign fall_edge = rx_prev & ~rx_sync;

  // last tick of a full bit slot
  assign slot_end = tick_i && (tick_cnt_q == TICK_LAST);

  assign sample_data = (state_q == RX_DATA) && slot_end;
  assign stop_good   = (state_q == RX_STOP) && slot_end && rx_sync;

  // ====================
  // frame FSM
  // ====================

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      rx_meta       <= 1'b1;
      rx_sync       <= 1'b1;
      rx_prev       <= 1'b1;
      state_q       <= RX_IDLE;
      tick_cnt_q    <= '0;
      bit_cnt_q     <= '0;
      word_strobe_o <= 1'b0;
    end else begin
      rx_meta       <= rx_i;
      rx_sync       <= rx_meta;
      rx_prev       <= rx_sync;
      word_strobe_o <= 1'b0;

      case (state_q)
        RX_IDLE: begin
          tick_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (fall_edge) begin
            state_q <= RX_START;
          end
        end

        RX_START: begin
          if (tick_i) begin
            if (tick_cnt_q == TICK_MID) begin
              tick_cnt_q <= '0;
              // line back high mid start bit means a glitch
              state_q    <= rx_sync ? RX_IDLE : RX_DATA;
            end else begin
              tick_cnt_q <= tick_cnt_q + 1'b1;
            end
          end
        end

        RX_DATA: begin
          if (slot_end) begin
            tick_cnt_q <= '0;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == BIT_LAST) begin
              state_q <= RX_STOP;
            end
          end else if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
        end

        RX_STOP: begin
          if (slot_end) begin
            // low stop sample drops the frame silently
            state_q       <= RX_IDLE;
            word_strobe_o <= rx_sync;
          end else if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
        end

        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // ====================
  // data path
  // ====================

  // lsb arrives first, so shift in from the top
  always_ff @(posedge clk_pixel) begin
    if (sample_data) begin
      shift_q <= {rx_sync, shift_q[`COM_WORD_W-1:1]};
    end
    if (stop_good) begin
      word_o <= shift_q;
    end
  end

  // the store updates once per strobe cycle, a long pulse would still be one word
  a_strobe_pulse : assert property (
    @(posedge clk_pixel) disable iff (recent_reset) word_strobe_o |=> !word_strobe_o
  );

endmodule

`default_nettype wire

// File: secondary_com_store.sv
`default_nettype none

`include "centroid_link_cfg.svh"

module secondary_com_store
  import centroid_link_pkg::*;
(
  input  logic                  clk_pixel,
  input  logic                  recent_reset,
  input  com_word_t             lane_word_i   [`NUM_LANES],
  input  logic [`NUM_LANES-1:0] lane_strobe_i,
  output hpos_t                 sec_x_o       [`NUM_COMS],
  output vpos_t                 sec_y_o       [`NUM_COMS]
);

  // ====================
  // lane to centroid map
  // ====================

  // lanes 0..3 carry x of centroid 0..3
  // lanes 4..7 carry y of the same centroids
  // x and y land independently, so a centroid may be half updated for a while

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      // all-ones sits past both screen edges, so nothing is drawn
      for (int i = 0; i < `NUM_COMS; i++) begin
        sec_x_o[i] <= '1;
        sec_y_o[i] <= '1;
      end
    end else begin
      for (int i = 0; i < `NUM_COMS; i++) begin
        if (lane_strobe_i[i]) begin
          sec_x_o[i] <= lane_word_i[i];
        end
        // y words are padded to 11 bits by the sender, top bit dropped here
        if (lane_strobe_i[i + `NUM_COMS]) begin
          sec_y_o[i] <= lane_word_i[i + `NUM_COMS][$bits(vpos_t)-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: crosshair_overlay.sv
`default_nettype none

`include "centroid_link_cfg.svh"

module crosshair_overlay
  import centroid_link_pkg::*;
(
  input  logic  clk_pixel,
  input  logic  recent_reset,
  input  hpos_t hpos_i,
  input  vpos_t vpos_i,
  input  logic  active_i,
  input  rgb_t  pixel_i,
  input  logic  com_valid_i,
  input  hpos_t local_x_i [`NUM_COMS],
  input  vpos_t local_y_i [`NUM_COMS],
  input  hpos_t sec_x_i   [`NUM_COMS],
  input  vpos_t sec_y_i   [`NUM_COMS],
  output rgb_t  pixel_o
);

  // colour per crosshair, index matches centroid number
  localparam rgb_t LOCAL_COLORS [`NUM_COMS] = '{
    `COLOR_LOCAL0, `COLOR_LOCAL1, `COLOR_LOCAL2, `COLOR_LOCAL3
  };
  localparam rgb_t SEC_COLORS [`NUM_COMS] = '{
    `COLOR_SEC0, `COLOR_SEC1, `COLOR_SEC2, `COLOR_SEC3
  };

  hpos_t loc_x_q [`NUM_COMS];
  vpos_t loc_y_q [`NUM_COMS];
  rgb_t  pixel_d;

  // ====================
  // local centroid hold
  // ====================

  // tracker strobes a full set at once, keep it until the next one
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      // off-screen until the tracker reports
      for (int i = 0; i < `NUM_COMS; i++) begin
        loc_x_q[i] <= '1;
        loc_y_q[i] <= '1;
      end
    end else if (com_valid_i) begin
      for (int i = 0; i < `NUM_COMS; i++) begin
        loc_x_q[i] <= local_x_i[i];
        loc_y_q[i] <= local_y_i[i];
      end
    end
  end

  // ====================
  // crosshair painter
  // ====================

  // walk crosshairs from local 0 up to secondary 3
  // each match overwrites, so the last one in the walk wins
  always_comb begin
    pixel_d = pixel_i;
    for (int i = 0; i < `NUM_COMS; i++) begin
      if ((vpos_i == loc_y_q[i]) || (hpos_i == loc_x_q[i])) begin
        pixel_d = LOCAL_COLORS[i];
      end
    end
    for (int i = 0; i < `NUM_COMS; i++) begin
      if ((vpos_i == sec_y_i[i]) || (hpos_i == sec_x_i[i])) begin
        pixel_d = SEC_COLORS[i];
      end
    end
    // blanking is always black
    if (!active_i) begin
      pixel_d = '0;
    end
  end

  // one register stage breaks the compare chain from the output
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      pixel_o <= '0;
    end else begin
      pixel_o <= pixel_d;
    end
  end

  // all-ones coordinates only hide a crosshair if active stays on screen
  a_active_on_screen : assert property (
    @(posedge clk_pixel) disable iff (recent_reset)
    active_i |-> (hpos_i < `SCREEN_W) && (vpos_i < `SCREEN_H)
  );

endmodule

`default_nettype wire

// File: centroid_link_top.sv
`default_nettype none

`include "centroid_link_cfg.svh"

module centroid_link_top
  import centroid_link_pkg::*;
(
  input  logic                  clk_pixel,
  input  logic                  recent_reset,
  // serial lines from the secondary board
  input  logic [`NUM_LANES-1:0] rx_i,
  // video position and pixel stream
  input  hpos_t                 hpos_i,
  input  vpos_t                 vpos_i,
  input  logic                  active_i,
  input  rgb_t                  pixel_i,
  // local tracker results
  input  logic                  com_valid_i,
  input  hpos_t                 local_x_i [`NUM_COMS],
  input  vpos_t                 local_y_i [`NUM_COMS],
  output rgb_t                  pixel_o
);

  logic                  tick;
  com_word_t             lane_word   [`NUM_LANES];
  logic [`NUM_LANES-1:0] lane_strobe;
  hpos_t                 sec_x       [`NUM_COMS];
  vpos_t                 sec_y       [`NUM_COMS];

  // ====================
  // secondary link
  // ====================

  // one tick source keeps all lanes on the same oversampling grid
  oversample_tick_gen u_tick_gen (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .tick_o       (tick)
  );

  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
    uart_lane_rx u_lane_rx (
      .clk_pixel     (clk_pixel),
      .recent_reset  (recent_reset),
      .rx_i          (rx_i[g]),
      .tick_i        (tick),
      .word_o        (lane_word[g]),
      .word_strobe_o (lane_strobe[g])
    );
  end

  secondary_com_store u_store (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .lane_word_i   (lane_word),
    .lane_strobe_i (lane_strobe),
    .sec_x_o       (sec_x),
    .sec_y_o       (sec_y)
  );

  // ====================
  // overlay
  // ====================

  crosshair_overlay u_overlay (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .hpos_i       (hpos_i),
    .vpos_i       (vpos_i),
    .active_i     (active_i),
    .pixel_i      (pixel_i),
    .com_valid_i  (com_valid_i),
    .local_x_i    (local_x_i),
    .local_y_i    (local_y_i),
    .sec_x_i      (sec_x),
    .sec_y_i      (sec_y),
    .pixel_o      (pixel_o)
  );

endmodule

`default_nettype wire

// File: tb_centroid_link_top.sv
`default_nettype none

`include "centroid_link_cfg.svh"

module tb_centroid_link_top
  import centroid_link_pkg::*;
();

  // one UART bit in pixel clocks
  localparam int BIT_CLKS = `CLKS_PER_TICK * `TICKS_PER_BIT;

  localparam rgb_t LOC_COLORS [`NUM_COMS] = '{
    `COLOR_LOCAL0, `COLOR_LOCAL1, `COLOR_LOCAL2, `COLOR_LOCAL3
  };
  localparam rgb_t SEC_COLORS [`NUM_COMS] = '{
    `COLOR_SEC0, `COLOR_SEC1, `COLOR_SEC2, `COLOR_SEC3
  };

  logic                  clk_pixel;
  logic                  recent_reset;
  logic [`NUM_LANES-1:0] rx;
  hpos_t                 hpos;
  vpos_t                 vpos;
  logic                  active;
  rgb_t                  pixel_in;
  logic                  com_valid;
  hpos_t                 local_x [`NUM_COMS];
  vpos_t                 local_y [`NUM_COMS];
  rgb_t                  pixel_out;

  // centroids the DUT is expected to hold
  hpos_t ref_lx [`NUM_COMS];
  vpos_t ref_ly [`NUM_COMS];
  hpos_t ref_sx [`NUM_COMS];
  vpos_t ref_sy [`NUM_COMS];

  int errors;
  int checks;

  initial begin
    clk_pixel = 1'b0;
    forever #20 clk_pixel = ~clk_pixel;
  end

  centroid_link_top uut (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .rx_i         (rx),
    .hpos_i       (hpos),
    .vpos_i       (vpos),
    .active_i     (active),
    .pixel_i      (pixel_in),
    .com_valid_i  (com_valid),
    .local_x_i    (local_x),
    .local_y_i    (local_y),
    .pixel_o      (pixel_out)
  );

  // ====================
  // helpers
  // ====================

  // inputs change a little after the edge, outputs are read there too
  task automatic step();
    @(posedge clk_pixel);
    #2;
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, expected);
      errors++;
    end
  endtask

  function automatic hpos_t rand_h();
    return hpos_t'($urandom % `SCREEN_W);
  endfunction

  function automatic vpos_t rand_v();
    return vpos_t'($urandom % `SCREEN_H);
  endfunction

  // search from the strongest crosshair down, first hit gives the colour
  function automatic rgb_t expected_pixel(hpos_t h, vpos_t v, logic act, rgb_t pix);
    if (!act) begin
      return '0;
    end
    for (int i = `NUM_COMS - 1; i >= 0; i--) begin
      if (h == ref_sx[i] || v == ref_sy[i]) begin
        return SEC_COLORS[i];
      end
    end
    for (int i = `NUM_COMS - 1; i >= 0; i--) begin
      if (h == ref_lx[i] || v == ref_ly[i]) begin
        return LOC_COLORS[i];
      end
    end
    return pix;
  endfunction

  // one random pixel in, compare one cycle later
  task automatic check_pixel(input hpos_t h, input vpos_t v, input logic act);
    rgb_t pix;
    rgb_t exp_pix;
    pix      = rgb_t'($urandom);
    exp_pix  = expected_pixel(h, v, act, pix);
    hpos     = h;
    vpos     = v;
    active   = act;
    pixel_in = pix;
    step();
    check_equal(pixel_out, exp_pix, $sformatf("pixel at x %0d y %0d", h, v));
  endtask

  task automatic drive_bit(input int lane, input logic b);
    rx[lane] = b;
    repeat (BIT_CLKS) @(posedge clk_pixel);
    #2;
  endtask

  // start bit, 11 data bits lsb first, then the given stop level
  task automatic send_frame(input int lane, input com_word_t word, input logic stop_bit);
    logic seen;
    drive_bit(lane, 1'b0);
    for (int i = 0; i < `COM_WORD_W; i++) begin
      drive_bit(lane, word[i]);
    end
    rx[lane] = stop_bit;
    seen     = 1'b0;
    // watch the lane strobe through the stop bit and one idle bit
    for (int n = 0; n < 2 * BIT_CLKS && !seen; n++) begin
      if (n == BIT_CLKS) begin
        rx[lane] = 1'b1;
      end
      step();
      seen = uut.lane_strobe[lane];
    end
    rx[lane] = 1'b1;
    if (stop_bit && !seen) begin
      $display("ERROR: lane %0d never reported its word (timeout)", lane);
      errors++;
    end
    if (!stop_bit && seen) begin
      $display("ERROR: lane %0d accepted a frame with a low stop bit", lane);
      errors++;
    end
    // store picks the word up one cycle after the strobe
    step();
  endtask

  // ====================
  // tests
  // ====================

  task automatic test_passthrough();
    for (int n = 0; n < 20; n++) begin
      check_pixel(rand_h(), rand_v(), 1'b1);
    end
    for (int n = 0; n < 5; n++) begin
      check_pixel(rand_h(), rand_v(), 1'b0);
    end
  endtask

  task automatic test_local();
    for (int i = 0; i < `NUM_COMS; i++) begin
      local_x[i] = rand_h();
      local_y[i] = rand_v();
      ref_lx[i]  = local_x[i];
      ref_ly[i]  = local_y[i];
    end
    com_valid = 1'b1;
    step();
    com_valid = 1'b0;
    for (int i = 0; i < `NUM_COMS; i++) begin
      check_pixel(ref_lx[i], rand_v(), 1'b1);
      check_pixel(rand_h(), ref_ly[i], 1'b1);
    end
    // every column against every row, higher index should win
    for (int i = 0; i < `NUM_COMS; i++) begin
      for (int j = 0; j < `NUM_COMS; j++) begin
        check_pixel(ref_lx[i], ref_ly[j], 1'b1);
      end
    end
    // new x values without a strobe stay unseen
    for (int i = 0; i < `NUM_COMS; i++) begin
      local_x[i] = rand_h();
    end
    for (int i = 0; i < `NUM_COMS; i++) begin
      check_pixel(local_x[i], rand_v(), 1'b1);
    end
  endtask

  task automatic test_secondary();
    hpos_t wx;
    vpos_t wy;
    wx = rand_h();
    wy = rand_v();
    fork
      send_frame(0, com_word_t'(wx), 1'b1);
      send_frame(`NUM_COMS, com_word_t'(wy), 1'b1);
    join
    ref_sx[0] = wx;
    ref_sy[0] = wy;
    check_pixel(wx, rand_v(), 1'b1);
    check_pixel(rand_h(), wy, 1'b1);
    // secondary 0 crosses each local crosshair
    for (int i = 0; i < `NUM_COMS; i++) begin
      check_pixel(ref_lx[i], wy, 1'b1);
      check_pixel(wx, ref_ly[i], 1'b1);
    end
  endtask

  task automatic test_all_lanes();
    com_word_t words [`NUM_LANES];
    for (int i = 0; i < `NUM_COMS; i++) begin
      ref_sx[i] = rand_h();
      ref_sy[i] = rand_v();
      words[i]  = com_word_t'(ref_sx[i]);
      // y words carry a set top bit that the store must drop
      words[i + `NUM_COMS] = {1'b1, ref_sy[i]};
    end
    fork
      send_frame(0, words[0], 1'b1);
      send_frame(1, words[1], 1'b1);
      send_frame(2, words[2], 1'b1);
      send_frame(3, words[3], 1'b1);
      send_frame(4, words[4], 1'b1);
      send_frame(5, words[5], 1'b1);
      send_frame(6, words[6], 1'b1);
      send_frame(7, words[7], 1'b1);
    join
    for (int i = 0; i < `NUM_COMS; i++) begin
      check_pixel(ref_sx[i], rand_v(), 1'b1);
      check_pixel(rand_h(), ref_sy[i], 1'b1);
    end
  endtask

  task automatic test_framing();
    hpos_t bad_x;
    bad_x = rand_h();
    if (bad_x == ref_sx[0]) begin
      bad_x = bad_x ^ hpos_t'(1);
    end
    send_frame(0, com_word_t'(bad_x), 1'b0);
    // old column still drawn, rejected one not
    check_pixel(ref_sx[0], rand_v(), 1'b1);
    check_pixel(bad_x, rand_v(), 1'b1);
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    void'($urandom(88138));
    errors       = 0;
    checks       = 0;
    recent_reset = 1'b1;
    rx           = '1;
    hpos         = '0;
    vpos         = '0;
    active       = 1'b0;
    pixel_in     = '0;
    com_valid    = 1'b0;
    for (int i = 0; i < `NUM_COMS; i++) begin
      local_x[i] = '0;
      local_y[i] = '0;
      ref_lx[i]  = '1;
      ref_ly[i]  = '1;
      ref_sx[i]  = '1;
      ref_sy[i]  = '1;
    end
    repeat (10) @(posedge clk_pixel);
    #2;
    recent_reset = 1'b0;

    test_passthrough();
    test_local();
    test_secondary();
    test_all_lanes();
    test_framing();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: centroid_link_top.f
+incdir+.
centroid_link_pkg.sv
oversample_tick_gen.sv
uart_lane_rx.sv
secondary_com_store.sv
crosshair_overlay.sv
centroid_link_top.sv
tb_centroid_link_top.sv

// File: Bender.yml
package:
  name: centroid_link

export_include_dirs:
  - .

sources:
  - centroid_link_pkg.sv
  - oversample_tick_gen.sv
  - uart_lane_rx.sv
  - secondary_com_store.sv
  - crosshair_overlay.sv
  - centroid_link_top.sv
  - target: test
    files:
      - tb_centroid_link_top.sv
